// File: source/cr16_pkg.sv
/*
 * Shared types for the CR16 core: widths, opcode and state encodings,
 * the instruction layout and the structs passed between blocks.
 * Every RTL file of the core imports this package.
 */
package cr16_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_COUNT = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0]        reg_idx_t;

    // Primary opcode, instruction bits 15:12
    typedef enum logic [3:0] {
        EXT_ALU = 4'b0000,
        ADDI    = 4'b0001,
        SUBI    = 4'b0100,
        CMPI    = 4'b0101,
        ANDI    = 4'b0111,
        ORI     = 4'b1000,
        XORI    = 4'b1001,
        MOVIL   = 4'b1010,
        MOVIU   = 4'b1011,
        BCOND   = 4'b1100,
        EXT_SYS = 4'b1111
    } opcode_e;

    // Extension, bits 7:4; ALU ops under EXT_ALU, the rest under EXT_SYS
    typedef enum logic [3:0] {
        ADD   = 4'b0000,
        MOV   = 4'b0001,
        SUB   = 4'b0011,
        CMP   = 4'b0100,
        AND   = 4'b0110,
        OR    = 4'b0111,
        XOR   = 4'b1000,
        LOAD  = 4'b1010,
        STORE = 4'b1011
    } ext_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_CLEAR
    } alu_op_e;

    // Branch conditions, carried in the Rdest field
    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_CS = 4'b0010,
        COND_CC = 4'b0011,
        COND_FS = 4'b0100,
        COND_FC = 4'b0101,
        COND_LT = 4'b0110,
        COND_LE = 4'b0111,
        COND_LO = 4'b1000,
        COND_LS = 4'b1001,
        COND_GT = 4'b1010,
        COND_GE = 4'b1011,
        COND_HI = 4'b1100,
        COND_HS = 4'b1101,
        COND_UC = 4'b1110
    } cond_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC_ALU,
        S_EXEC_MOV,
        S_BRANCH_WAIT,
        S_LOAD_WAIT,
        S_LOAD_WRITE,
        S_STORE
    } state_e;

    // Immediate forms use {ext, rsrc} as the 8-bit immediate
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rdest;
        ext_e     ext;
        reg_idx_t rsrc;
    } instr_t;

    typedef struct packed {
        logic negative;
        logic zero;
        logic flag;
        logic low;
        logic carry;
    } flags_t;

    typedef struct packed {
        reg_idx_t a_sel;
        reg_idx_t b_sel;
        word_t    imm;
        logic     imm_sel;
        alu_op_e  alu_op;
        logic     wr_en;
        logic     wr_data_sel;
    } dp_ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

endpackage

// File: source/cr16_alu.sv
/*
 * Combinational ALU of the CR16 core.
 * dest is the Rdest operand, src is Rsrc or the decoded immediate.
 */
`timescale 1ns/1ps

module cr16_alu (
    input  cr16_pkg::alu_op_e op,
    input  cr16_pkg::word_t   src,
    input  cr16_pkg::word_t   dest,
    output cr16_pkg::word_t   result,
    output cr16_pkg::flags_t  flags
);
    import cr16_pkg::*;

    always_comb begin
        result = '0;
        flags  = '0;

        // Compare-style flags, shared by every real op
        flags.zero     = (dest == src);
        flags.low      = (dest < src);
        flags.negative = ($signed(dest) < $signed(src));

        case (op)
            ALU_ADD: begin
                {flags.carry, result} = {1'b0, dest} + {1'b0, src};
                flags.flag = (dest[WORD_W-1] == src[WORD_W-1]) &&
                             (result[WORD_W-1] != dest[WORD_W-1]);
            end
            ALU_SUB: begin
                // Carry holds the borrow out of dest - src
                {flags.carry, result} = {1'b0, dest} - {1'b0, src};
                flags.flag = (dest[WORD_W-1] != src[WORD_W-1]) &&
                             (result[WORD_W-1] != dest[WORD_W-1]);
            end
            ALU_AND: result = dest & src;
            ALU_OR:  result = dest | src;
            ALU_XOR: result = dest ^ src;
            default: begin
                // CLEAR and anything unknown drive all outputs low
                result = '0;
                flags  = '0;
            end
        endcase
    end

endmodule

// File: source/cr16_regfile.sv
/*
 * Register file of the CR16 core: sixteen words, two asynchronous
 * read ports and one write port that is frozen while enable is low.
 */
`timescale 1ns/1ps

module cr16_regfile (
    input  logic               I_CLK,
    input  logic               I_NRESET,
    input  logic               enable,
    input  cr16_pkg::reg_idx_t a_sel,
    input  cr16_pkg::reg_idx_t b_sel,
    input  logic               wr_en,
    input  cr16_pkg::reg_idx_t wr_sel,
    input  cr16_pkg::word_t    wr_data,
    output cr16_pkg::word_t    a,
    output cr16_pkg::word_t    b
);
    import cr16_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (enable && wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // a is Rsrc, b is Rdest
    assign a = regs[a_sel];
    assign b = regs[b_sel];

endmodule

// File: source/cr16_control.sv
/*
 * Controller of the CR16 core: FSM, instruction register, decode,
 * program counter and status flags. It steers the datapath through
 * dp_ctrl and drives the single memory port combinationally.
 */
`timescale 1ns/1ps

module cr16_control (
    input  logic               I_CLK,
    input  logic               I_NRESET,
    input  logic               enable,
    input  cr16_pkg::word_t    mem_rdata,
    input  cr16_pkg::word_t    a,
    input  cr16_pkg::word_t    b,
    input  cr16_pkg::flags_t   alu_flags,
    output cr16_pkg::dp_ctrl_t dp_ctrl,
    output cr16_pkg::word_t    mov_data,
    output cr16_pkg::mem_req_t mem_req,
    output cr16_pkg::word_t    pc
);
    import cr16_pkg::*;

    state_e   state;
    instr_t   instr_q;
    flags_t   flags_q;
    logic [7:0] imm8;
    word_t    disp;
    cond_e    cond;
    alu_op_e  alu_op;
    word_t    imm;
    logic     imm_sel;
    logic     is_alu;
    logic     is_cmp;
    logic     is_mov;
    logic     is_load;
    logic     is_store;
    logic     cond_true;

    assign imm8 = {instr_q.ext, instr_q.rsrc};
    assign disp = {{8{imm8[7]}}, imm8};
    assign cond = cond_e'(instr_q.rdest);

    assign is_cmp   = (instr_q.opcode == CMPI) ||
                      (instr_q.opcode == EXT_ALU && instr_q.ext == CMP);
    assign is_mov   = (instr_q.opcode == MOVIL) || (instr_q.opcode == MOVIU) ||
                      (instr_q.opcode == EXT_SYS && instr_q.ext == MOV);
    assign is_load  = (instr_q.opcode == EXT_SYS && instr_q.ext == LOAD);
    assign is_store = (instr_q.opcode == EXT_SYS && instr_q.ext == STORE);

    // ALU op and immediate decode
    always_comb begin
        alu_op  = ALU_CLEAR;
        imm     = '0;
        imm_sel = 1'b0;
        is_alu  = 1'b1;
        case (instr_q.opcode)
            EXT_ALU: begin
                case (instr_q.ext)
                    ADD:      alu_op = ALU_ADD;
                    SUB, CMP: alu_op = ALU_SUB;
                    AND:      alu_op = ALU_AND;
                    OR:       alu_op = ALU_OR;
                    XOR:      alu_op = ALU_XOR;
                    default:  is_alu = 1'b0;
                endcase
            end
            ADDI, SUBI, CMPI: begin
                alu_op  = (instr_q.opcode == ADDI) ? ALU_ADD : ALU_SUB;
                imm     = disp;
                imm_sel = 1'b1;
            end
            ANDI, ORI, XORI: begin
                // Logic immediates are zero-extended
                alu_op  = (instr_q.opcode == ANDI) ? ALU_AND :
                          (instr_q.opcode == ORI)  ? ALU_OR  : ALU_XOR;
                imm     = {8'h00, imm8};
                imm_sel = 1'b1;
            end
            default: is_alu = 1'b0;
        endcase
    end

    // Branch condition against the stored flags
    always_comb begin
        case (cond)
            COND_EQ: cond_true = flags_q.zero;
            COND_NE: cond_true = !flags_q.zero;
            COND_CS: cond_true = flags_q.carry;
            COND_CC: cond_true = !flags_q.carry;
            COND_FS: cond_true = flags_q.flag;
            COND_FC: cond_true = !flags_q.flag;
            COND_LT: cond_true = !flags_q.negative && !flags_q.zero;
            COND_LE: cond_true = !flags_q.negative;
            COND_LO: cond_true = !flags_q.low && !flags_q.zero;
            COND_LS: cond_true = !flags_q.low;
            COND_GT: cond_true = flags_q.negative;
            COND_GE: cond_true = flags_q.negative || flags_q.zero;
            COND_HI: cond_true = flags_q.low;
            COND_HS: cond_true = flags_q.low || flags_q.zero;
            COND_UC: cond_true = 1'b1;
            default: cond_true = 1'b0;
        endcase
    end

    always_ff @(posedge I_CLK or negedge I_NRESET) begin
        if (!I_NRESET) begin
            state   <= S_FETCH;
            instr_q <= '0;
            flags_q <= '0;
            pc      <= '0;
        end else if (enable) begin
            case (state)
                S_FETCH: begin
                    instr_q <= instr_t'(mem_rdata);
                    pc      <= pc + word_t'(1);
                    state   <= S_DECODE;
                end
                S_DECODE: begin
                    if (instr_q.opcode == BCOND) begin
                        // PC already points past the branch
                        if (cond_true) begin
                            pc    <= pc + disp;
                            state <= S_BRANCH_WAIT;
                        end else begin
                            state <= S_FETCH;
                        end
                    end else if (is_alu) begin
                        state <= S_EXEC_ALU;
                    end else if (is_mov) begin
                        state <= S_EXEC_MOV;
                    end else if (is_load) begin
                        state <= S_LOAD_WAIT;
                    end else if (is_store) begin
                        state <= S_STORE;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                S_EXEC_ALU: begin
                    flags_q <= alu_flags;
                    state   <= S_FETCH;
                end
                S_LOAD_WAIT: state <= S_LOAD_WRITE;
                default:     state <= S_FETCH;
            endcase
        end
    end

    always_comb begin
        dp_ctrl.a_sel       = instr_q.rsrc;
        dp_ctrl.b_sel       = instr_q.rdest;
        dp_ctrl.imm         = imm;
        dp_ctrl.imm_sel     = imm_sel;
        dp_ctrl.alu_op      = alu_op;
        dp_ctrl.wr_en       = (state == S_EXEC_ALU && !is_cmp) ||
                              (state == S_EXEC_MOV) || (state == S_LOAD_WRITE);
        dp_ctrl.wr_data_sel = (state == S_EXEC_MOV) || (state == S_LOAD_WRITE);
    end

    // Write-back data for MOV, MOVIL, MOVIU and LOAD
    always_comb begin
        if (state == S_LOAD_WRITE) begin
            mov_data = mem_rdata;
        end else if (instr_q.opcode == MOVIL) begin
            mov_data = {8'h00, imm8};
        end else if (instr_q.opcode == MOVIU) begin
            mov_data = {imm8, 8'h00};
        end else begin
            mov_data = a;
        end
    end

    always_comb begin
        mem_req.addr  = pc;
        mem_req.wdata = '0;
        mem_req.we    = 1'b0;
        case (state)
            S_LOAD_WAIT, S_LOAD_WRITE: mem_req.addr = a;
            S_STORE: begin
                mem_req.addr  = b;
                mem_req.wdata = a;
                // A frozen core must not repeat the write
                mem_req.we    = enable;
            end
            default: mem_req.addr = pc;
        endcase
    end

endmodule

// File: source/cr16_core.sv
/*
 * Top level of the cut-down CR16 core.
 * Connects the controller, register file and ALU; the memory sits
 * outside and is reached through mem_req and mem_rdata.
 */
`timescale 1ns/1ps

module cr16_core (
    input  logic               I_CLK,
    input  logic               I_NRESET,
    input  logic               enable,
    input  cr16_pkg::word_t    mem_rdata,
    output cr16_pkg::mem_req_t mem_req,
    output cr16_pkg::word_t    pc
);
    import cr16_pkg::*;

    dp_ctrl_t dp_ctrl;
    word_t    a;
    word_t    b;
    word_t    mov_data;
    word_t    alu_src;
    word_t    alu_result;
    word_t    wr_data;
    flags_t   alu_flags;

    cr16_control i_cr16_control (
        .I_CLK     (I_CLK),
        .I_NRESET  (I_NRESET),
        .enable    (enable),
        .mem_rdata (mem_rdata),
        .a         (a),
        .b         (b),
        .alu_flags (alu_flags),
        .dp_ctrl   (dp_ctrl),
        .mov_data  (mov_data),
        .mem_req   (mem_req),
        .pc        (pc)
    );

    // Rdest is both the B operand and the write target
    cr16_regfile i_cr16_regfile (
        .I_CLK    (I_CLK),
        .I_NRESET (I_NRESET),
        .enable   (enable),
        .a_sel    (dp_ctrl.a_sel),
        .b_sel    (dp_ctrl.b_sel),
        .wr_en    (dp_ctrl.wr_en),
        .wr_sel   (dp_ctrl.b_sel),
        .wr_data  (wr_data),
        .a        (a),
        .b        (b)
    );

    assign alu_src = dp_ctrl.imm_sel ? dp_ctrl.imm : a;

    cr16_alu i_cr16_alu (
        .op     (dp_ctrl.alu_op),
        .src    (alu_src),
        .dest   (b),
        .result (alu_result),
        .flags  (alu_flags)
    );

    assign wr_data = dp_ctrl.wr_data_sel ? mov_data : alu_result;

endmodule

// File: verif/cr16_asserts.sv
/*
 * Concurrent assertions on the CR16 controller, bound to every
 * cr16_control instance. Covers the store strobe and the reset PC.
 */
`timescale 1ns/1ps

module cr16_asserts (
    input logic               I_CLK,
    input logic               I_NRESET,
    input cr16_pkg::state_e   state,
    input cr16_pkg::mem_req_t mem_req,
    input cr16_pkg::word_t    pc
);
    import cr16_pkg::*;

    we_only_in_store: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        mem_req.we |-> state == S_STORE)
        else $error("write strobe outside the STORE state");

    we_single_cycle: assert property (@(posedge I_CLK) disable iff (!I_NRESET)
        mem_req.we |=> !mem_req.we)
        else $error("write strobe held for two cycles");

    pc_zero_after_reset: assert property (@(posedge I_CLK)
        $rose(I_NRESET) |-> pc == '0)
        else $error("PC not zero after reset release");

endmodule

bind cr16_control cr16_asserts i_cr16_asserts (
    .I_CLK    (I_CLK),
    .I_NRESET (I_NRESET),
    .state    (state),
    .mem_req  (mem_req),
    .pc       (pc)
);

// File: verif/cr16_tb.sv
/*
 * Testbench for the CR16 core. Loads program words and the expected
 * results from the case file, models a 256-word memory, checks every
 * store and the final PC, and freezes the core once with enable low.
 */
`timescale 1ns/1ps

module cr16_tb;
    import cr16_pkg::*;

    localparam int MEM_WORDS = 256;

    logic     I_CLK = 1'b0;
    logic     I_NRESET;
    logic     enable;
    word_t    mem_rdata;
    mem_req_t mem_req;
    word_t    pc;

    word_t mem [MEM_WORDS];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t final_pc;
    int    prog_words  = 0;
    int    store_idx   = 0;
    int    errors      = 0;
    bit    cases_ok    = 1'b0;
    bit    cases_read  = 1'b0;
    int unsigned stall_start;
    int unsigned stall_len;

    cr16_core i_cr16_core (
        .I_CLK     (I_CLK),
        .I_NRESET  (I_NRESET),
        .enable    (enable),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .pc        (pc)
    );

    always #2 I_CLK = ~I_CLK;

    // Combinational read, write on the rising edge
    assign mem_rdata = mem[mem_req.addr[7:0]];

    always @(posedge I_CLK) begin
        if (mem_req.we) begin
            mem[mem_req.addr[7:0]] <= mem_req.wdata;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    // Address and strobe only; store data goes through check_word
    task automatic check_req(input string name, input mem_req_t got, input mem_req_t exp);
        if (got.addr !== exp.addr || got.we !== exp.we) begin
            errors++;
            $display("** Error: %s addr/we = %h/%h, expected %h/%h",
                     name, got.addr, got.we, exp.addr, exp.we);
        end
    endtask

    task automatic read_cases();
        int          fd;
        string       line;
        byte         kind;
        int unsigned v1;
        int unsigned v2;
        fd = $fopen("verif/cr16_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("The case file could not be opened");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1) begin
                    kind = line.getc(0);
                    v1 = 0;
                    v2 = 0;
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h", v1, v2));
                    if (kind == "P") begin
                        mem[v1[7:0]] = word_t'(v2);
                        prog_words++;
                    end else if (kind == "S") begin
                        exp_addr.push_back(word_t'(v1));
                        exp_data.push_back(word_t'(v2));
                    end else if (kind == "H") begin
                        final_pc = word_t'(v1);
                    end
                end
            end
            $fclose(fd);
            cases_ok = 1'b1;
        end
    endtask

    // Store monitor, sampled mid-cycle where the request is stable
    always @(negedge I_CLK) begin
        mem_req_t exp;
        if (I_NRESET && mem_req.we) begin
            if (!enable) begin
                errors++;
                $display("A store happened while enable was low");
            end else if (store_idx >= exp_addr.size()) begin
                errors++;
                $display("A store happened after all expected stores were seen");
            end else begin
                exp.addr  = exp_addr[store_idx];
                exp.wdata = exp_data[store_idx];
                exp.we    = 1'b1;
                check_req("mem_req", mem_req, exp);
                check_word("mem_req.wdata", mem_req.wdata, exp_data[store_idx]);
                store_idx++;
            end
        end
    end

    task automatic run_program();
        mem_req_t idle;
        int       hits;
        idle.addr  = '0;
        idle.wdata = '0;
        idle.we    = 1'b0;
        repeat (8) @(posedge I_CLK);
        #0.5 I_NRESET = 1'b1;
        @(negedge I_CLK);
        check_req("mem_req", mem_req, idle);
        check_word("pc", pc, '0);
        // First fetch done, PC moved past address 0
        @(negedge I_CLK);
        check_word("pc", pc, word_t'(1));

        fork
            begin
                repeat (stall_start) @(posedge I_CLK);
                #0.5 enable = 1'b0;
                repeat (stall_len) @(posedge I_CLK);
                #0.5 enable = 1'b1;
            end
        join_none

        wait (store_idx == exp_addr.size());

        // The self-branch keeps the PC at H except in DECODE
        hits = 0;
        while (hits < 10) begin
            @(negedge I_CLK);
            if (enable) begin
                if (pc == final_pc) begin
                    hits++;
                end else if (pc != final_pc + word_t'(1)) begin
                    check_word("pc", pc, final_pc);
                    hits = 10;
                end
            end
        end
    endtask

    initial begin
        I_NRESET = 1'b0;
        enable   = 1'b1;
        void'($urandom(14));
        stall_start = 20 + ($urandom % 150);
        stall_len   = $urandom % 8;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 16'hC300 | word_t'(i);
        end
        read_cases();
        cases_read = 1'b1;
        if (cases_ok) begin
            run_program();
        end
        $display("Stores seen: %0d of %0d, errors: %0d", store_idx, exp_addr.size(), errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        int limit;
        wait (cases_read);
        limit = 20 * prog_words + 200 + 16;
        repeat (limit) @(posedge I_CLK);
        $display("Watchdog expired before the program completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: verif/cr16_cases.txt
# P addr word: program or data word; S addr data: expected store, in order
# H addr: expected final PC (the self-branch); all values hex
P 0000 AF80
P 0001 A134
P 0002 B212
P 0003 0271
P 0004 FFB2
P 0005 1F01
P 0006 A30F
P 0007 0302
P 0008 FFB3
P 0009 1F01
P 000A 0331
P 000B FFB3
P 000C 1F01
P 000D 13FE
P 000E FFB3
P 000F 1F01
P 0010 0362
P 0011 93FF
P 0012 FFB3
P 0013 1F01
P 0014 73F0
P 0015 0381
P 0016 4304
P 0017 FFB3
P 0018 1F01
P 0019 0341
P 001A FFB3
P 001B A4E1
P 001C C001
P 001D A4D1
P 001E FFB4
P 001F A4E2
P 0020 C101
P 0021 A4D2
P 0022 FFB4
P 0023 A4E3
P 0024 C201
P 0025 A4D3
P 0026 FFB4
P 0027 A4E4
P 0028 C601
P 0029 A4D4
P 002A FFB4
P 002B A4E5
P 002C CC01
P 002D A4D5
P 002E FFB4
P 002F 5140
P 0030 A4E6
P 0031 C201
P 0032 A4D6
P 0033 FFB4
P 0034 A4E7
P 0035 C601
P 0036 A4D7
P 0037 FFB4
P 0038 A4E8
P 0039 CC01
P 003A A4D8
P 003B FFB4
P 003C 5134
P 003D A4E9
P 003E C001
P 003F A4D9
P 0040 FFB4
P 0041 A5F0
P 0042 F6A5
P 0043 F716
P 0044 FFB7
P 0045 CEFF
P 00F0 BEEF
S 0080 1234
S 0081 1243
S 0082 120F
S 0083 120D
S 0084 12FB
S 0085 00C0
S 0086 00C0
S 0086 00D1
S 0086 00E2
S 0086 00D3
S 0086 00E4
S 0086 00D5
S 0086 00E6
S 0086 00D7
S 0086 00E8
S 0086 00E9
S 0086 BEEF
H 0045

// File: project.f
source/cr16_pkg.sv
source/cr16_alu.sv
source/cr16_regfile.sv
source/cr16_control.sv
source/cr16_core.sv
verif/cr16_asserts.sv
verif/cr16_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CR16 testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module cr16_tb \
    -Mdir obj_dir -o cr16_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/cr16_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
